//--- src/splash_pkg.sv
package splash_pkg;

	// Bit 2 red, bit 1 green, bit 0 blue
	typedef logic [2:0] pixel_t;

	localparam pixel_t COL_BLACK = 3'b000;
	localparam pixel_t COL_RED   = 3'b100;
	localparam pixel_t COL_BLUE  = 3'b001;
	localparam pixel_t COL_WHITE = 3'b111;

	typedef enum logic [1:0]
	{
		IMG_TITLE,
		IMG_BLACK,
		IMG_GAMEOVER,
		IMG_RED
	} image_t;

	typedef enum logic [3:0]
	{
		PAINT_TITLE    = 4'd0,
		TITLE          = 4'd1,
		PAINT_BLACK    = 4'd2,
		PLAY           = 4'd3,
		PAINT_GAMEOVER = 4'd4,
		GAMEOVER_WAIT  = 4'd5,
		PAINT_RED      = 4'd6,
		FLASH_WAIT     = 4'd7,
		RESTART_WAIT   = 4'd8
	} seq_state_t;

endpackage

//--- src/flash_timer.sv
`timescale 1ns/1ps

module flash_timer #(
	parameter int FLASH_PERIOD = 1000
)
(
	input  logic clk,
	input  logic rst,
	input  logic flash_en,
	output logic tick
);

	localparam int CW = (FLASH_PERIOD > 1) ? $clog2(FLASH_PERIOD) : 1;

	logic [CW-1:0] count;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (!flash_en)
		begin
			count <= '0; // Restart the period on every enable
			tick <= 1'b0;
		end
		else if (count == CW'(FLASH_PERIOD - 1))
		begin
			count <= '0;
			tick <= 1'b1;
		end
		else
		begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

//--- src/screen_painter.sv
`timescale 1ns/1ps

module screen_painter import splash_pkg::*; #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
)
(
	input  logic clk,
	input  logic rst,
	input  logic paint_req,
	input  image_t paint_image,
	output logic paint_ack,
	output logic wr_en,
	output logic [$clog2(SCREEN_W*SCREEN_H)-1:0] wr_addr,
	output pixel_t wr_pixel
);

	localparam int NPIX = SCREEN_W * SCREEN_H;
	localparam int AW = $clog2(NPIX);
	localparam int XW = $clog2(SCREEN_W);
	localparam int YW = $clog2(SCREEN_H);

	typedef enum logic [1:0] {P_IDLE, P_PAINT, P_DONE} paint_state_t;

	paint_state_t state;
	image_t image;
	logic [AW-1:0] addr;
	logic [XW-1:0] x;
	logic [YW-1:0] y;
	logic [XW-1:0] x_tile;
	logic [YW-1:0] y_tile;
	logic last;
	pixel_t colour;

	assign last = (addr == AW'(NPIX - 1));
	assign x_tile = x >> 3; // 8x8 checker tiles
	assign y_tile = y >> 3;

	always_comb
	begin
		case (image)
			IMG_TITLE: colour = (x_tile[0] ^ y_tile[0]) ? COL_WHITE : COL_BLUE;
			IMG_GAMEOVER: colour = y[2] ? COL_BLACK : COL_RED; // Stripes 4 rows high
			IMG_RED: colour = COL_RED;
			default: colour = COL_BLACK;
		endcase
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state <= P_IDLE;
			addr <= '0;
			x <= '0;
			y <= '0;
			wr_en <= 1'b0;
			paint_ack <= 1'b0;
		end
		else
		begin
			wr_en <= (state == P_PAINT); // Output stage is one cycle behind the walk
			paint_ack <= (state == P_DONE) && paint_req;
			case (state)
				P_IDLE:
					if (paint_req)
					begin
						state <= P_PAINT;
						addr <= '0;
						x <= '0;
						y <= '0;
					end
				P_PAINT:
				begin
					addr <= addr + 1'b1;
					if (x == XW'(SCREEN_W - 1))
					begin
						x <= '0;
						y <= y + 1'b1;
					end
					else
						x <= x + 1'b1;
					if (last)
						state <= P_DONE;
				end
				P_DONE:
					if (!paint_req)
						state <= P_IDLE;
				default:
					state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == P_IDLE && paint_req)
			image <= paint_image; // Held for the whole paint
		wr_addr <= addr;
		wr_pixel <= colour;
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst)
		paint_ack |-> $past(paint_req));

	a_no_write_on_ack: assert property (@(posedge clk) disable iff (!rst)
		!(wr_en && paint_ack));

endmodule

//--- src/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import splash_pkg::*; #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120
)
(
	input  logic clk,
	input  logic wr_en,
	input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0] wr_addr,
	input  pixel_t wr_pixel,
	input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0] rd_addr,
	output pixel_t rd_pixel
);

	localparam int DEPTH = SCREEN_W * SCREEN_H;

	pixel_t mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_pixel;
	end

	// Display side, one cycle latency
	always_ff @(posedge clk)
	begin
		rd_pixel <= mem[rd_addr];
	end

endmodule

//--- src/splash_sequencer.sv
`timescale 1ns/1ps

module splash_sequencer import splash_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  logic   dead,
	input  logic   tick,
	input  logic   paint_ack,
	output logic   paint_req,
	output image_t paint_image,
	output logic   flash_en,
	output logic   go,
	output logic   game_reset,
	output logic   busy
);

	seq_state_t state;
	seq_state_t next_state;
	logic painting;

	always_comb
	begin
		next_state = state;
		case (state)
			PAINT_TITLE:
				if (paint_ack)
					next_state = TITLE;
			TITLE:
				if (start)
					next_state = PAINT_BLACK;
			PAINT_BLACK:
				if (paint_ack)
					next_state = PLAY;
			PLAY:
				if (dead)
					next_state = PAINT_GAMEOVER;
			PAINT_GAMEOVER:
				if (paint_ack)
					next_state = GAMEOVER_WAIT;
			GAMEOVER_WAIT:
			begin
				if (!start)
					next_state = RESTART_WAIT; // Key let go, stop flashing
				else if (tick)
					next_state = PAINT_RED;
			end
			PAINT_RED:
				if (paint_ack)
					next_state = FLASH_WAIT;
			FLASH_WAIT:
			begin
				if (!start)
					next_state = RESTART_WAIT;
				else if (tick)
					next_state = PAINT_GAMEOVER;
			end
			RESTART_WAIT:
				if (start)
					next_state = PAINT_TITLE;
			default:
				next_state = PAINT_TITLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			state <= PAINT_TITLE;
		else
			state <= next_state;
	end

	assign painting = (state == PAINT_TITLE) || (state == PAINT_BLACK) ||
		(state == PAINT_GAMEOVER) || (state == PAINT_RED);

	always_comb
	begin
		case (state)
			PAINT_BLACK: paint_image = IMG_BLACK;
			PAINT_GAMEOVER: paint_image = IMG_GAMEOVER;
			PAINT_RED: paint_image = IMG_RED;
			default: paint_image = IMG_TITLE;
		endcase
	end

	assign paint_req = painting; // Drops the cycle after ack is seen
	assign busy = painting;
	assign flash_en = (state == GAMEOVER_WAIT) || (state == FLASH_WAIT);
	assign go = (state == PLAY);
	assign game_reset = (state == RESTART_WAIT);

	// Request and image hold until the painter answers
	a_req_hold: assert property (@(posedge clk) disable iff (!rst)
		paint_req && !paint_ack |=> paint_req && $stable(paint_image));

endmodule

//--- src/splash_top.sv
`timescale 1ns/1ps

module splash_top import splash_pkg::*; #(
	parameter int SCREEN_W = 160,
	parameter int SCREEN_H = 120,
	parameter int FLASH_PERIOD = 12_500_000
)
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic dead,
	input  logic [$clog2(SCREEN_W*SCREEN_H)-1:0] rd_addr,
	output pixel_t rd_pixel,
	output logic go,
	output logic game_reset,
	output logic busy
);

	localparam int AW = $clog2(SCREEN_W * SCREEN_H);

	logic paint_req;
	logic paint_ack;
	image_t paint_image;
	logic flash_en;
	logic tick;
	logic wr_en;
	logic [AW-1:0] wr_addr;
	pixel_t wr_pixel;

	splash_sequencer splash_sequencer_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.dead        (dead),
		.tick        (tick),
		.paint_ack   (paint_ack),
		.paint_req   (paint_req),
		.paint_image (paint_image),
		.flash_en    (flash_en),
		.go          (go),
		.game_reset  (game_reset),
		.busy        (busy)
	);

	flash_timer #(.FLASH_PERIOD(FLASH_PERIOD)) flash_timer_i (
		.clk      (clk),
		.rst      (rst),
		.flash_en (flash_en),
		.tick     (tick)
	);

	screen_painter #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) screen_painter_i (
		.clk         (clk),
		.rst         (rst),
		.paint_req   (paint_req),
		.paint_image (paint_image),
		.paint_ack   (paint_ack),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_pixel    (wr_pixel)
	);

	frame_buffer #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) frame_buffer_i (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_pixel (wr_pixel),
		.rd_addr  (rd_addr),
		.rd_pixel (rd_pixel)
	);

endmodule

//--- bench/splash_tb.sv
`timescale 1ns/1ps

module splash_tb
	import splash_pkg::*;
();

	localparam int SCREEN_W = 16;
	localparam int SCREEN_H = 8;
	localparam int FLASH_PERIOD = 300;
	localparam int NPIX = SCREEN_W * SCREEN_H;
	localparam int AW = $clog2(NPIX);
	localparam int NROUNDS = 4;

	// Reset paint plus ten phases per round with room for four flashes
	localparam int PHASES = 1 + NROUNDS * 10;
	localparam longint WATCHDOG_NS = longint'(PHASES) * (NPIX + FLASH_PERIOD + 50) * 10;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic dead;
	logic [AW-1:0] rd_addr;
	pixel_t rd_pixel;
	logic go;
	logic game_reset;
	logic busy;

	int seed;

	// Reference model of the game phases
	seq_state_t model_state = PAINT_TITLE;
	image_t exp_image = IMG_TITLE;
	int wait_cnt = 0;
	int paint_cnt = 0;

	splash_top #(
		.SCREEN_W     (SCREEN_W),
		.SCREEN_H     (SCREEN_H),
		.FLASH_PERIOD (FLASH_PERIOD)
	) splash_top_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.dead       (dead),
		.rd_addr    (rd_addr),
		.rd_pixel   (rd_pixel),
		.go         (go),
		.game_reset (game_reset),
		.busy       (busy)
	);

	always #5 clk = ~clk;

	task automatic check_value(logic [31:0] actual, logic [31:0] expected, string msg);
		if (actual !== expected)
		begin
			$display("Error at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch, run stopped");
		end
	endtask

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped");
	endtask

	function automatic int random_between(int lo, int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic bit is_paint(seq_state_t s);
		return (s == PAINT_TITLE) || (s == PAINT_BLACK) ||
			(s == PAINT_GAMEOVER) || (s == PAINT_RED);
	endfunction

	function automatic image_t image_of(seq_state_t s);
		case (s)
			PAINT_BLACK: return IMG_BLACK;
			PAINT_GAMEOVER: return IMG_GAMEOVER;
			PAINT_RED: return IMG_RED;
			default: return IMG_TITLE;
		endcase
	endfunction

	function automatic seq_state_t after_paint(seq_state_t s);
		case (s)
			PAINT_BLACK: return PLAY;
			PAINT_GAMEOVER: return GAMEOVER_WAIT;
			PAINT_RED: return FLASH_WAIT;
			default: return TITLE;
		endcase
	endfunction

	// Colour of one pixel from the x/y pattern rules
	function automatic pixel_t expected_pixel(image_t img, int addr);
		int x;
		int y;
		x = addr % SCREEN_W;
		y = addr / SCREEN_W;
		case (img)
			IMG_TITLE: return (((x / 8 + y / 8) % 2) == 1) ? COL_WHITE : COL_BLUE;
			IMG_GAMEOVER: return (((y / 4) % 2) == 0) ? COL_RED : COL_BLACK;
			IMG_RED: return COL_RED;
			default: return COL_BLACK;
		endcase
	endfunction

	task automatic enter_paint(seq_state_t s);
		model_state = s;
		paint_cnt = 0;
	endtask

	// Advances the model by the posedge that just passed, using the inputs held over it
	task automatic model_step();
		case (model_state)
			PAINT_TITLE, PAINT_BLACK, PAINT_GAMEOVER, PAINT_RED:
			begin
				if (!busy)
				begin
					check_value(paint_cnt >= NPIX, 1, "paint ended before the whole frame");
					exp_image = image_of(model_state);
					model_state = after_paint(model_state);
					wait_cnt = 0;
				end
				else if (paint_cnt > NPIX + 10)
					abort_run("Paint did not finish within the expected time");
				else
					paint_cnt++;
			end
			TITLE:
				if (start)
					enter_paint(PAINT_BLACK);
			PLAY:
				if (dead)
					enter_paint(PAINT_GAMEOVER);
			GAMEOVER_WAIT, FLASH_WAIT:
			begin
				if (!start)
					model_state = RESTART_WAIT;
				else if (wait_cnt == FLASH_PERIOD) // Tick is seen one cycle after it fires
				begin
					if (model_state == GAMEOVER_WAIT)
						enter_paint(PAINT_RED);
					else
						enter_paint(PAINT_GAMEOVER);
				end
				else
					wait_cnt++;
			end
			RESTART_WAIT:
				if (start)
					enter_paint(PAINT_TITLE);
			default:
				abort_run("Model reached an unknown state");
		endcase
	endtask

	task automatic check_outputs();
		check_value(go, model_state == PLAY, "go against model");
		check_value(game_reset, model_state == RESTART_WAIT, "game_reset against model");
		if (!is_paint(model_state))
			check_value(busy, 0, "busy outside a paint");
		else if (paint_cnt == 0)
			check_value(busy, 1, "busy at paint start");
	endtask

	// Advance one clock and check the model against the DUT
	task automatic step_cycle();
		@(negedge clk);
		model_step();
		check_outputs();
	endtask

	task automatic idle_cycles(int n);
		repeat (n)
			step_cycle();
	endtask

	task automatic wait_paint_start();
		while (!is_paint(model_state))
			step_cycle();
	endtask

	task automatic wait_paint_end();
		while (is_paint(model_state))
			step_cycle();
	endtask

	// Reads back every address; rd_pixel lags rd_addr by one clock
	task automatic read_frame(image_t img);
		int a;
		rd_addr = '0;
		for (a = 0; a < NPIX; a++)
		begin
			step_cycle();
			check_value(rd_pixel, expected_pixel(img, a),
				$sformatf("frame pixel %0d of image %0d", a, img));
			rd_addr = AW'(a + 1);
		end
	endtask

	task automatic press_start();
		start = 1'b1;
		idle_cycles(random_between(1, 40));
		start = 1'b0;
	endtask

	task automatic play_round(int r);
		int flashes;
		int f;

		// Title to play
		press_start();
		wait_paint_end();
		read_frame(exp_image);
		check_value(go, 1, "go during play");
		idle_cycles(random_between(5, 100));

		// Player grabs the key, then dies
		start = 1'b1;
		idle_cycles(random_between(1, 10));
		dead = 1'b1;
		idle_cycles(random_between(1, 3));
		dead = 1'b0;
		wait_paint_end();
		check_value(go, 0, "go after dead");
		read_frame(exp_image);

		// Flashing while the key is held
		flashes = random_between(2, 4);
		for (f = 0; f < flashes; f++)
		begin
			wait_paint_start();
			wait_paint_end();
			read_frame(exp_image);
		end

		// Release, then press again for the title
		idle_cycles(random_between(0, 50));
		start = 1'b0;
		step_cycle();
		check_value(game_reset, 1, "game_reset after release");
		idle_cycles(random_between(1, 30));
		start = 1'b1;
		step_cycle();
		check_value(game_reset, 0, "game_reset after new press");
		idle_cycles(random_between(0, 20));
		start = 1'b0;
		wait_paint_end();
		read_frame(exp_image);
		$display("Round %0d done at %0t ns with %0d flashes", r, $time, flashes);
	endtask

	initial
	begin
		seed = 32'h6fec5c60;
		rst = 1'b0;
		start = 1'b0;
		dead = 1'b0;
		rd_addr = '0;
		repeat (8)
			@(negedge clk);
		rst = 1'b1;

		// Title paint right after reset
		wait_paint_end();
		read_frame(exp_image);
		check_value(go, 0, "go after reset");
		check_value(game_reset, 0, "game_reset after reset");

		for (int r = 0; r < NROUNDS; r++)
			play_round(r);

		$display("STATUS: PASS");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("Watchdog expired before the test sequence finished");
	end

endmodule

//--- filelist.f
src/splash_pkg.sv
src/flash_timer.sv
src/screen_painter.sv
src/frame_buffer.sv
src/splash_sequencer.sv
src/splash_top.sv
bench/splash_tb.sv
